/* hdl/div_isa_pkg.sv */
package div_isa_pkg;

    // physical register tag from the rename stage
    typedef logic [7:0] phys_tag_t;

    typedef logic [31:0] pc_t;

    // divide path opcodes, 4 bit field as carried through the core
    typedef enum logic [3:0] {
        op_div  = 4'h0,  // signed quotient
        op_divu = 4'h1,
        op_rem  = 4'h2,  // signed remainder
        op_remu = 4'h3
    } div_op_e;

endpackage

/* hdl/rs_pkg.sv */
package rs_pkg;

    // dispatch record, 62 bits
    typedef struct packed {
        div_isa_pkg::pc_t       pc;
        div_isa_pkg::phys_tag_t dst;
        div_isa_pkg::div_op_e   op;
        div_isa_pkg::phys_tag_t src1;
        div_isa_pkg::phys_tag_t src2;
        logic                   src1_rdy;  // ready as known at rename
        logic                   src2_rdy;
    } rs_dispatch_t;

    // one result bus
    typedef struct packed {
        logic                   valid;
        div_isa_pkg::phys_tag_t tag;
    } rs_bcast_t;

    // record handed to the divide unit, 61 bits
    typedef struct packed {
        logic                   valid;
        div_isa_pkg::pc_t       pc;
        div_isa_pkg::phys_tag_t dst;
        div_isa_pkg::div_op_e   op;
        div_isa_pkg::phys_tag_t src1;
        div_isa_pkg::phys_tag_t src2;
    } rs_issue_t;

    typedef enum logic [1:0] {
        idle      = 2'd0,
        acked     = 2'd1,  // first cycle with ack high
        wait_drop = 2'd2   // ack held until req falls
    } alloc_state_e;

endpackage

/* hdl/rs_alloc_ctrl.sv */
`timescale 1ns/1ps

module rs_alloc_ctrl #(
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  logic                     alloc_req,
    output logic                     alloc_ack,
    input  logic [DEPTH-1:0]         busy,
    output logic                     wr_en,
    output logic [$clog2(DEPTH)-1:0] wr_idx,
    output logic [$clog2(DEPTH)-1:0] head
);
    import rs_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    alloc_state_e     state;
    alloc_state_e     state_nxt;
    logic [IDX_W-1:0] tail;
    logic [IDX_W:0]   count;  // occupied slots incl. holes
    logic             full;
    logic             retire;

    assign full   = (count == (IDX_W+1)'(DEPTH));
    assign wr_en  = (state == idle) && alloc_req && !full && !flush;
    assign retire = (count != '0) && !busy[head];  // issued slot at head
    assign wr_idx = tail;

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (wr_en) begin
                    state_nxt = acked;
                end
            end
            acked: begin
                state_nxt = alloc_req ? wait_drop : idle;
            end
            wait_drop: begin
                if (!alloc_req) begin
                    state_nxt = idle;
                end
            end
            default: state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= idle;
            alloc_ack <= 1'b0;
        end else begin
            state     <= state_nxt;
            alloc_ack <= (state_nxt != idle);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                tail <= tail + 1'b1;  // wraps, DEPTH is a power of two
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            case ({wr_en, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hdl/rs_wakeup.sv */
`timescale 1ns/1ps

module rs_wakeup #(
    parameter int DEPTH     = 16,
    parameter int NUM_BCAST = 4
) (
    input  div_isa_pkg::phys_tag_t [DEPTH-1:0]     src1_tags,
    input  div_isa_pkg::phys_tag_t [DEPTH-1:0]     src2_tags,
    input  rs_pkg::rs_dispatch_t                   dispatch,
    input  rs_pkg::rs_bcast_t      [NUM_BCAST-1:0] bcast,
    output logic                   [DEPTH-1:0]     set1,
    output logic                   [DEPTH-1:0]     set2,
    output logic                                   byp1,
    output logic                                   byp2
);
    import div_isa_pkg::*;
    import rs_pkg::*;

    // any valid bus carrying this tag
    function automatic logic tag_hit(input phys_tag_t tag,
                                     input rs_bcast_t [NUM_BCAST-1:0] bus);
        logic hit;
        hit = 1'b0;
        for (int b = 0; b < NUM_BCAST; b++) begin
            hit = hit | (bus[b].valid && (bus[b].tag == tag));
        end
        return hit;
    endfunction

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            set1[i] = tag_hit(src1_tags[i], bcast);
            set2[i] = tag_hit(src2_tags[i], bcast);
        end
    end

    // same-cycle broadcast seen by the entry being written
    assign byp1 = tag_hit(dispatch.src1, bcast);
    assign byp2 = tag_hit(dispatch.src2, bcast);

endmodule

/* hdl/rs_entry_array.sv */
`timescale 1ns/1ps

module rs_entry_array #(
    parameter int DEPTH = 16
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   flush,
    input  logic                                   wr_en,
    input  logic                   [$clog2(DEPTH)-1:0] wr_idx,
    input  rs_pkg::rs_dispatch_t                   dispatch,
    input  logic                                   byp1,
    input  logic                                   byp2,
    input  logic                   [DEPTH-1:0]     set1,
    input  logic                   [DEPTH-1:0]     set2,
    input  logic                   [DEPTH-1:0]     clr,
    output logic                   [DEPTH-1:0]     busy,
    output logic                   [DEPTH-1:0]     rdy1,
    output logic                   [DEPTH-1:0]     rdy2,
    output rs_pkg::rs_dispatch_t   [DEPTH-1:0]     entries,
    output div_isa_pkg::phys_tag_t [DEPTH-1:0]     src1_tags,
    output div_isa_pkg::phys_tag_t [DEPTH-1:0]     src2_tags
);

    // payload storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[wr_idx] <= dispatch;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            busy <= '0;
            rdy1 <= '0;
            rdy2 <= '0;
        end else begin
            busy <= busy & ~clr;
            rdy1 <= rdy1 | set1;
            rdy2 <= rdy2 | set2;
            if (wr_en) begin  // new entry overrides stale wakeup on its slot
                busy[wr_idx] <= 1'b1;
                rdy1[wr_idx] <= dispatch.src1_rdy | byp1;
                rdy2[wr_idx] <= dispatch.src2_rdy | byp2;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            src1_tags[i] = entries[i].src1;
            src2_tags[i] = entries[i].src2;
        end
    end

endmodule

/* hdl/rs_issue_select.sv */
`timescale 1ns/1ps

module rs_issue_select #(
    parameter int DEPTH  = 16,
    parameter int WINDOW = 8
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               flush,
    input  logic                 [$clog2(DEPTH)-1:0] head,
    input  logic                 [DEPTH-1:0]   busy,
    input  logic                 [DEPTH-1:0]   rdy1,
    input  logic                 [DEPTH-1:0]   rdy2,
    input  rs_pkg::rs_dispatch_t [DEPTH-1:0]   entries,
    output logic                 [DEPTH-1:0]   clr,
    output rs_pkg::rs_issue_t                  issue
);

    localparam int IDX_W = $clog2(DEPTH);

    logic             found;
    logic [IDX_W-1:0] sel;

    // first ready entry counting from head, oldest wins
    always_comb begin
        logic [IDX_W-1:0] idx;
        found = 1'b0;
        sel   = '0;
        idx   = '0;
        for (int off = 0; off < WINDOW; off++) begin
            idx = head + IDX_W'(off);  // wraps at DEPTH
            if (!found && busy[idx] && rdy1[idx] && rdy2[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
    end

    always_comb begin
        clr = '0;
        if (found) begin
            clr[sel] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            issue <= '0;
        end else if (found) begin
            issue.valid <= 1'b1;
            issue.pc    <= entries[sel].pc;
            issue.dst   <= entries[sel].dst;
            issue.op    <= entries[sel].op;
            issue.src1  <= entries[sel].src1;
            issue.src2  <= entries[sel].src2;
        end else begin
            issue <= '0;  // one-cycle record
        end
    end

endmodule

/* hdl/div_rs_top.sv */
`timescale 1ns/1ps

module div_rs_top #(
    parameter int DEPTH     = 16,
    parameter int WINDOW    = 8,
    parameter int NUM_BCAST = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 flush,
    input  logic                                 alloc_req,
    output logic                                 alloc_ack,
    input  rs_pkg::rs_dispatch_t                 dispatch,
    input  rs_pkg::rs_bcast_t    [NUM_BCAST-1:0] bcast,
    output rs_pkg::rs_issue_t                    issue
);
    import div_isa_pkg::*;
    import rs_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    logic                         wr_en;
    logic         [IDX_W-1:0]     wr_idx;
    logic         [IDX_W-1:0]     head;
    logic         [DEPTH-1:0]     busy;
    logic         [DEPTH-1:0]     rdy1;
    logic         [DEPTH-1:0]     rdy2;
    logic         [DEPTH-1:0]     set1;
    logic         [DEPTH-1:0]     set2;
    logic         [DEPTH-1:0]     clr;
    logic                         byp1;
    logic                         byp2;
    rs_dispatch_t [DEPTH-1:0]     entries;
    phys_tag_t    [DEPTH-1:0]     src1_tags;
    phys_tag_t    [DEPTH-1:0]     src2_tags;

    rs_alloc_ctrl #(
        .DEPTH(DEPTH)
    ) i_alloc (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .alloc_req(alloc_req),
        .alloc_ack(alloc_ack),
        .busy(busy),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .head(head)
    );

    rs_wakeup #(
        .DEPTH(DEPTH),
        .NUM_BCAST(NUM_BCAST)
    ) i_wakeup (
        .src1_tags(src1_tags),
        .src2_tags(src2_tags),
        .dispatch(dispatch),
        .bcast(bcast),
        .set1(set1),
        .set2(set2),
        .byp1(byp1),
        .byp2(byp2)
    );

    rs_entry_array #(
        .DEPTH(DEPTH)
    ) i_entries (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .dispatch(dispatch),
        .byp1(byp1),
        .byp2(byp2),
        .set1(set1),
        .set2(set2),
        .clr(clr),
        .busy(busy),
        .rdy1(rdy1),
        .rdy2(rdy2),
        .entries(entries),
        .src1_tags(src1_tags),
        .src2_tags(src2_tags)
    );

    rs_issue_select #(
        .DEPTH(DEPTH),
        .WINDOW(WINDOW)
    ) i_select (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .head(head),
        .busy(busy),
        .rdy1(rdy1),
        .rdy2(rdy2),
        .entries(entries),
        .clr(clr),
        .issue(issue)
    );

endmodule

/* sim/tb_div_rs.sv */
`timescale 1ns/1ps

module tb_div_rs;
    import div_isa_pkg::*;
    import rs_pkg::*;

    localparam int DEPTH      = 16;
    localparam int WINDOW     = 8;
    localparam int NUM_BCAST  = 4;
    localparam int MAX_CYCLES = 3000;  // tests take about 400 cycles

    logic                         clk = 1'b0;
    logic                         rst_n;
    logic                         flush;
    logic                         alloc_req;
    logic                         alloc_ack;
    rs_dispatch_t                 dispatch;
    rs_bcast_t    [NUM_BCAST-1:0] bcast;
    rs_issue_t                    issue;

    integer    seed = 71;
    int        cycle = 0;
    int        err_cnt = 0;
    int        test_cnt = 0;
    int        test_fail = 0;
    int        ack_cyc;  // edge that raised alloc_ack
    int        bc_cyc;   // edge that sampled the last broadcast
    rs_issue_t iss_q[$];
    int        iss_cyc_q[$];

    div_rs_top #(
        .DEPTH(DEPTH),
        .WINDOW(WINDOW),
        .NUM_BCAST(NUM_BCAST)
    ) i_dut (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .alloc_req(alloc_req),
        .alloc_ack(alloc_ack),
        .dispatch(dispatch),
        .bcast(bcast),
        .issue(issue)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: no progress, run stopped after %0d cycles", cycle);
            $display(">>> FAIL");
            $finish;
        end
    end

    // every issued record with its cycle
    always @(negedge clk) begin
        if (rst_n && issue.valid) begin
            iss_q.push_back(issue);
            iss_cyc_q.push_back(cycle);
        end
    end

    task automatic report_error(input string msg);
        $display("FAILED at time %0t: %s", $time, msg);
        err_cnt++;
    endtask

    function automatic rs_dispatch_t make_dispatch(input logic r1, input logic r2);
        rs_dispatch_t d;
        logic [3:0]   op_sel;
        op_sel     = $random(seed) & 3;
        d.pc       = $random(seed);
        d.pc[1:0]  = 2'b00;  // word aligned
        d.dst      = $random(seed);
        d.op       = div_op_e'(op_sel);
        d.src1     = $random(seed);
        d.src2     = $random(seed);
        d.src1_rdy = r1;
        d.src2_rdy = r2;
        return d;
    endfunction

    task automatic start_req(input rs_dispatch_t d, input logic byp, input int bus,
                             input phys_tag_t t);
        @(posedge clk);
        alloc_req <= 1'b1;
        dispatch  <= d;
        if (byp) begin
            bcast[bus] <= '{valid: 1'b1, tag: t};  // held through the accept edge
        end
    endtask

    task automatic finish_req();
        @(negedge clk);
        while (!alloc_ack) begin
            @(negedge clk);
        end
        ack_cyc = cycle;
        @(posedge clk);
        alloc_req <= 1'b0;
        bcast     <= '0;
        @(negedge clk);
        while (alloc_ack) begin
            @(negedge clk);
        end
    endtask

    task automatic send_dispatch(input rs_dispatch_t d);
        start_req(d, 1'b0, 0, '0);
        finish_req();
    endtask

    task automatic drive_bcast(input int bus, input phys_tag_t t);
        @(posedge clk);
        bcast[bus] <= '{valid: 1'b1, tag: t};
        @(posedge clk);
        bcast <= '0;
        @(negedge clk);
        bc_cyc = cycle;
    endtask

    task automatic expect_issue(input rs_dispatch_t d, input int exp_cyc, input string label);
        rs_issue_t got;
        int        cyc;
        while (iss_q.size() == 0) begin
            @(negedge clk);
        end
        got = iss_q.pop_front();
        cyc = iss_cyc_q.pop_front();
        if (got.pc !== d.pc || got.dst !== d.dst || got.op !== d.op ||
            got.src1 !== d.src1 || got.src2 !== d.src2) begin
            report_error($sformatf("%s: issued pc %h dst %h op %0d, expected pc %h dst %h op %0d",
                                   label, got.pc, got.dst, got.op, d.pc, d.dst, d.op));
        end
        if (exp_cyc >= 0 && cyc != exp_cyc) begin
            report_error($sformatf("%s: issued in cycle %0d, expected %0d", label, cyc, exp_cyc));
        end
    endtask

    task automatic expect_none(input int n, input string label);
        repeat (n) @(posedge clk);
        if (iss_q.size() != 0) begin
            report_error($sformatf("%s: %0d unexpected issue records", label, iss_q.size()));
            iss_q.delete();
            iss_cyc_q.delete();
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            test_fail++;
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic test_ready_dispatch();
        rs_dispatch_t d;
        int           e0;
        e0 = err_cnt;
        @(negedge clk);
        if (issue.valid !== 1'b0 || alloc_ack !== 1'b0) begin
            report_error("issue.valid or alloc_ack high after reset");
        end
        d = make_dispatch(1'b1, 1'b1);
        send_dispatch(d);
        expect_issue(d, ack_cyc + 1, "ready dispatch");
        expect_none(5, "ready dispatch");
        end_test("ready_dispatch", e0);
    endtask

    task automatic test_wakeup();
        rs_dispatch_t d;
        int           e0;
        e0 = err_cnt;
        d = make_dispatch(1'b1, 1'b0);
        send_dispatch(d);
        expect_none(10, "waiting on src2");
        drive_bcast(2, d.src2);
        expect_issue(d, bc_cyc + 1, "src2 wakeup");
        expect_none(5, "src2 wakeup");
        end_test("wakeup", e0);
    endtask

    task automatic test_oldest_first();
        rs_dispatch_t old_d;
        rs_dispatch_t young_d;
        int           e0;
        e0 = err_cnt;
        old_d   = make_dispatch(1'b0, 1'b1);
        young_d = make_dispatch(1'b1, 1'b1);
        send_dispatch(old_d);
        send_dispatch(young_d);
        expect_issue(young_d, ack_cyc + 1, "younger ready entry");
        expect_none(5, "older entry waiting");
        drive_bcast(1, old_d.src1);
        expect_issue(old_d, bc_cyc + 1, "older entry after wakeup");
        expect_none(5, "older entry after wakeup");
        end_test("oldest_first", e0);
    endtask

    task automatic test_bypass();
        rs_dispatch_t d;
        int           e0;
        e0 = err_cnt;
        d = make_dispatch(1'b1, 1'b0);
        start_req(d, 1'b1, 3, d.src2);
        finish_req();
        expect_issue(d, ack_cyc + 1, "bypass");
        expect_none(5, "bypass");
        end_test("bypass", e0);
    endtask

    task automatic test_full();
        rs_dispatch_t held[DEPTH];
        rs_dispatch_t extra;
        phys_tag_t    wt;
        int           e0;
        e0 = err_cnt;
        wt = $random(seed);
        for (int i = 0; i < DEPTH; i++) begin
            held[i]      = make_dispatch(1'b0, 1'b1);
            held[i].src1 = wt;
            send_dispatch(held[i]);
        end
        extra = make_dispatch(1'b1, 1'b1);
        start_req(extra, 1'b0, 0, '0);
        repeat (20) begin
            @(negedge clk);
            if (alloc_ack !== 1'b0) begin
                report_error("alloc_ack raised while the station is full");
            end
        end
        expect_none(1, "full station waiting");
        drive_bcast(0, wt);
        if (alloc_ack !== 1'b0) begin
            report_error("pending request acknowledged before the wakeup");
        end
        finish_req();
        for (int i = 0; i < DEPTH; i++) begin
            expect_issue(held[i], bc_cyc + 1 + i, "full drain");
        end
        expect_issue(extra, -1, "request accepted after drain");
        expect_none(5, "full drain");
        end_test("full", e0);
    endtask

    task automatic test_flush();
        rs_dispatch_t w;
        rs_dispatch_t d;
        phys_tag_t    wt;
        int           e0;
        e0 = err_cnt;
        wt = $random(seed);
        for (int i = 0; i < 3; i++) begin
            w      = make_dispatch(1'b1, 1'b0);
            w.src2 = wt;
            send_dispatch(w);
        end
        expect_none(3, "before flush");
        @(posedge clk);
        bcast[2] <= '{valid: 1'b1, tag: wt};  // wakes them on the edge before the flush
        @(posedge clk);
        bcast <= '0;
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        if (issue.valid !== 1'b0 || alloc_ack !== 1'b0) begin
            report_error("issue.valid or alloc_ack high after flush");
        end
        drive_bcast(2, wt);
        expect_none(10, "flushed entries");
        d = make_dispatch(1'b1, 1'b1);
        send_dispatch(d);
        expect_issue(d, ack_cyc + 1, "dispatch after flush");
        expect_none(5, "dispatch after flush");
        end_test("flush", e0);
    endtask

    initial begin
        rst_n     = 1'b0;
        flush     = 1'b0;
        alloc_req = 1'b0;
        dispatch  = '0;
        bcast     = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        test_ready_dispatch();
        test_wakeup();
        test_oldest_first();
        test_bypass();
        test_full();
        test_flush();
        $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0 && test_fail == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* div_rs.f */
hdl/div_isa_pkg.sv
hdl/rs_pkg.sv
hdl/rs_alloc_ctrl.sv
hdl/rs_wakeup.sv
hdl/rs_entry_array.sv
hdl/rs_issue_select.sv
hdl/div_rs_top.sv
sim/tb_div_rs.sv
